/* vlog.f */
source/rvCorePkg.sv
source/aluDecoder.sv
source/alu.sv
source/registerFile.sv
source/fetchUnit.sv
source/loadStoreUnit.sv
source/busArbiter.sv
source/coreSequencer.sv
source/rvCore.sv
dv/memoryModel.sv
dv/rvCoreTb.sv

/* run.sh */
#!/bin/sh
# Build and run the testbench, exit status carries the result
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f vlog.f --top-module rvCoreTb -o rvCoreSim &&
./obj_dir/rvCoreSim || exit 1

/* dv/rvCoreTb.sv */
`timescale 1ns/100ps
`default_nettype none

module rvCoreTb;

    import rvCorePkg::*;

    localparam int      randomSeed  = 78;
    localparam dataWord dataBase    = 32'h0000_0400; // Operand pairs
    localparam dataWord resultBase  = 32'h0000_0600; // One slot per result
    localparam dataWord poisonAdr   = 32'h0000_07E0;
    localparam dataWord doneAdr     = 32'h0000_07F0;
    localparam dataWord poisonValue = 32'hFFFF_FBAD;

    logic    clk   = 1'b0;
    logic    reset = 1'b1;
    logic    wbCyc;
    logic    wbStb;
    logic    wbWe;
    logic    wbAck;
    dataWord wbAdr;
    dataWord wbDatW;
    dataWord wbDatR;
    logic    storeSeen;
    dataWord storeAdr;
    dataWord storeDat;

    // Test table
    string     rowName[$];
    aluControl rowControl[$];
    bit        rowImm[$];
    dataWord   rowA[$];
    dataWord   rowB[$];      // Sign-extended immediate on immediate rows
    dataWord   rowExpect[$];

    // Bus writes in program order
    dataWord expAdr[$];
    dataWord expDat[$];
    string   expTag[$];

    int     pcWord     = 0;
    int     slot       = 0;
    int     resetCount = 0;
    longint limitNs    = 0;
    bit     tableBuilt = 1'b0;

    rvCore #(.resetVector(32'h0000_0000)) i_rvCore (
        .clk    (clk),
        .reset  (reset),
        .wbCyc  (wbCyc),
        .wbStb  (wbStb),
        .wbWe   (wbWe),
        .wbAdr  (wbAdr),
        .wbDatW (wbDatW),
        .wbDatR (wbDatR),
        .wbAck  (wbAck)
    );

    memoryModel #(.seedInit(randomSeed)) memory (
        .clk      (clk),
        .reset    (reset),
        .wbCyc    (wbCyc),
        .wbStb    (wbStb),
        .wbWe     (wbWe),
        .wbAdr    (wbAdr),
        .wbDatW   (wbDatW),
        .wbDatR   (wbDatR),
        .wbAck    (wbAck),
        .logValid (storeSeen),
        .logAdr   (storeAdr),
        .logDat   (storeDat)
    );

    initial begin
        forever #10 clk = ~clk; // 20 ns period
    end

    // Reset high over four rising edges
    always @(posedge clk) begin
        if (resetCount < 4) begin
            resetCount <= resetCount + 1;
        end
        reset <= (resetCount < 3);
    end

    function automatic logic [2:0] funct3Of(aluControl c);
        case (c)
            aluSll:         return 3'b001;
            aluSlt:         return 3'b010;
            aluSltu:        return 3'b011;
            aluXor:         return 3'b100;
            aluSrl, aluSra: return 3'b101;
            aluOr:          return 3'b110;
            aluAnd:         return 3'b111;
            default:        return 3'b000; // ADD and SUB
        endcase
    endfunction

    // Instruction encoders
    function automatic dataWord rType(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                      logic [2:0] f3, logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, opRegister};
    endfunction

    function automatic dataWord iType(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                      logic [4:0] rd, opcode op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic dataWord sType(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], opStore}; // SW only
    endfunction

    function automatic dataWord bType(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                      logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opBranch};
    endfunction

    task automatic addRow(string name, aluControl c, bit imm, dataWord a, dataWord b,
                          dataWord e);
        rowName.push_back(name);
        rowControl.push_back(c);
        rowImm.push_back(imm);
        rowA.push_back(a);
        rowB.push_back(b);
        rowExpect.push_back(e);
    endtask

    // Name, function, immediate, A, B, expected result
    task automatic fillTable();
        addRow("add",   aluAdd,  1'b0, 32'h7FFF_FFFF, 32'h0000_0001, 32'h8000_0000); // Wraps
        addRow("sub",   aluSub,  1'b0, 32'h0000_0005, 32'h0000_000C, 32'hFFFF_FFF9);
        // Shift amounts over 31 keep five bits
        addRow("sll",   aluSll,  1'b0, 32'h8000_0003, 32'd35,        32'h0000_0018);
        addRow("slt",   aluSlt,  1'b0, 32'hFFFF_FFF0, 32'h0000_0001, 32'h0000_0001);
        addRow("sltu",  aluSltu, 1'b0, 32'hFFFF_FFF0, 32'h0000_0001, 32'h0000_0000);
        addRow("xor",   aluXor,  1'b0, 32'hA5A5_5A5A, 32'hFFFF_0000, 32'h5A5A_5A5A);
        addRow("srl",   aluSrl,  1'b0, 32'h8000_0000, 32'd63,        32'h0000_0001);
        addRow("sra",   aluSra,  1'b0, 32'h8000_0000, 32'd36,        32'hF800_0000);
        // Zero operand
        addRow("or",    aluOr,   1'b0, 32'h0000_0000, 32'h1234_0000, 32'h1234_0000);
        addRow("and",   aluAnd,  1'b0, 32'hF0F0_F0F0, 32'h0FF0_FFFF, 32'h00F0_F0F0);
        addRow("slt",   aluSlt,  1'b0, 32'h0000_0001, 32'hFFFF_FFFF, 32'h0000_0000);
        // Bit 30 set, still an add
        addRow("addi",  aluAdd,  1'b1, 32'h0000_0010, 32'h0000_04F0, 32'h0000_0500);
        addRow("addi",  aluAdd,  1'b1, 32'h0000_0010, 32'hFFFF_F800, 32'hFFFF_F810); // -2048
        addRow("slli",  aluSll,  1'b1, 32'h0000_0001, 32'h0000_001F, 32'h8000_0000);
        addRow("slti",  aluSlt,  1'b1, 32'hFFFF_FFFE, 32'hFFFF_FFFF, 32'h0000_0001);
        addRow("sltiu", aluSltu, 1'b1, 32'h0000_0005, 32'hFFFF_FFFF, 32'h0000_0001);
        addRow("xori",  aluXor,  1'b1, 32'h1234_5678, 32'hFFFF_FFFF, 32'hEDCB_A987);
        addRow("srli",  aluSrl,  1'b1, 32'hF000_0000, 32'h0000_0008, 32'h00F0_0000);
        addRow("srai",  aluSra,  1'b1, 32'hF000_0000, 32'h0000_0408, 32'hFFF0_0000);
        addRow("ori",   aluOr,   1'b1, 32'h0000_0F00, 32'hFFFF_FF0F, 32'hFFFF_FF0F);
        addRow("andi",  aluAnd,  1'b1, 32'hABCD_EF12, 32'h0000_07FF, 32'h0000_0712);
    endtask

    task automatic emit(dataWord word);
        memory.mem[10'(pcWord)] = word;
        pcWord++;
    endtask

    task automatic putData(dataWord adr, dataWord value);
        memory.mem[adr[11:2]] = value;
    endtask

    task automatic expectStore(dataWord adr, dataWord value, string tag);
        expAdr.push_back(adr);
        expDat.push_back(value);
        expTag.push_back(tag);
    endtask

    // SW rs2 into the next result slot through x6
    task automatic storeResult(logic [4:0] rs2, dataWord value, string tag);
        emit(sType(12'(4 * slot), rs2, 5'd6));
        expectStore(resultBase + 32'(4 * slot), value, tag);
        slot++;
    endtask

    task automatic buildProgram();
        logic [2:0] f3;
        logic [6:0] f7;
        dataWord    imm;
        for (int a = 0; a < 1024; a++) begin
            memory.mem[10'(a)] = 32'hC0DE_0000 ^ (32'(a) * 32'h0001_0001);
        end
        emit(iType(dataBase[11:0], 5'd0, 3'b000, 5'd5, opImmediate));   // x5 data base
        emit(iType(resultBase[11:0], 5'd0, 3'b000, 5'd6, opImmediate)); // x6 result base
        for (int i = 0; i < rowName.size(); i++) begin
            putData(dataBase + 32'(8 * i), rowA[i]);
            putData(dataBase + 32'(8 * i + 4), rowB[i]);
            f3  = funct3Of(rowControl[i]);
            imm = rowB[i];
            emit(iType(12'(8 * i), 5'd5, 3'b010, 5'd1, opLoad));
            if (rowImm[i]) begin
                emit(iType(imm[11:0], 5'd1, f3, 5'd3, opImmediate));
            end else begin
                f7 = (rowControl[i] == aluSub || rowControl[i] == aluSra) ? 7'h20 : 7'h00;
                emit(iType(12'(8 * i + 4), 5'd5, 3'b010, 5'd2, opLoad));
                emit(rType(f7, 5'd2, 5'd1, f3, 5'd3));
            end
            storeResult(5'd3, rowExpect[i], rowName[i]);
        end
        // Round trip through the data area, -1234
        emit(iType(12'hB2E, 5'd0, 3'b000, 5'd9, opImmediate));
        emit(sType(12'h1F0, 5'd9, 5'd5));
        expectStore(dataBase + 32'h1F0, 32'hFFFF_FB2E, "sw data");
        emit(iType(12'h1F0, 5'd5, 3'b010, 5'd10, opLoad));
        storeResult(5'd10, 32'hFFFF_FB2E, "lw back");
        // Branch operands and the poison marker
        emit(iType(12'd5, 5'd0, 3'b000, 5'd1, opImmediate));
        emit(iType(12'd5, 5'd0, 3'b000, 5'd2, opImmediate));
        emit(iType(12'd7, 5'd0, 3'b000, 5'd7, opImmediate));
        emit(iType(poisonValue[11:0], 5'd0, 3'b000, 5'd8, opImmediate));
        emit(bType(13'd8, 5'd2, 5'd1, 3'b000)); // BEQ taken
        emit(sType(poisonAdr[11:0], 5'd8, 5'd0));
        storeResult(5'd1, 32'd5, "beq taken");
        emit(bType(13'd8, 5'd2, 5'd1, 3'b001)); // BNE falls through
        storeResult(5'd7, 32'd7, "bne not taken");
        emit(bType(13'd8, 5'd7, 5'd1, 3'b001)); // BNE taken
        emit(sType(poisonAdr[11:0], 5'd8, 5'd0));
        storeResult(5'd7, 32'd7, "bne taken");
        emit(bType(13'd8, 5'd7, 5'd1, 3'b000)); // BEQ falls through
        storeResult(5'd2, 32'd5, "beq not taken");
        // Writes to x0 are dropped
        emit(iType(12'd123, 5'd0, 3'b000, 5'd0, opImmediate));
        emit(rType(7'h00, 5'd2, 5'd1, 3'b000, 5'd0));
        storeResult(5'd0, 32'd0, "x0");
        emit(sType(doneAdr[11:0], 5'd1, 5'd0));
        expectStore(doneAdr, 32'd5, "done");
        emit(bType(13'd0, 5'd0, 5'd0, 3'b000)); // Spin here
    endtask

    task automatic stopWithFailure(string reason);
        $display("%s", reason);
        $display("STATUS: FAIL");
        $fatal(1, "Run stopped on the first error");
    endtask

    task automatic checkWord(string name, dataWord actual, dataWord expected);
        if (actual !== expected) begin
            stopWithFailure($sformatf("** Error: %s = 0x%08h, expected 0x%08h",
                                      name, actual, expected));
        end
    endtask

    task automatic checkAddress(string name, dataWord actual, dataWord expected);
        if (actual !== expected) begin
            stopWithFailure($sformatf("** Error: %s = 0x%08h, expected 0x%08h",
                                      name, actual, expected));
        end
    endtask

    task automatic checkBit(string name, logic actual, logic expected);
        if (actual !== expected) begin
            stopWithFailure($sformatf("** Error: %s = 0x%0h, expected 0x%0h",
                                      name, actual, expected));
        end
    endtask

    // Done store is the last entry, so the queue never runs dry before it
    task automatic handleStore();
        dataWord adr;
        dataWord dat;
        string   tag;
        if (storeDat == poisonValue) begin
            stopWithFailure("Poison marker stored after a taken branch");
        end else begin
            adr = expAdr.pop_front();
            dat = expDat.pop_front();
            tag = expTag.pop_front();
            checkAddress({"wbAdr ", tag}, storeAdr, adr);
            checkWord({"wbDatW ", tag}, storeDat, dat);
            if (adr == doneAdr) begin
                $display("STATUS: PASS");
                $finish;
            end
        end
    endtask

    // Bus idle under reset, then each logged write in order
    always @(negedge clk) begin
        if (reset && resetCount != 0) begin
            checkBit("wbCyc", wbCyc, 1'b0);
            checkBit("wbStb", wbStb, 1'b0);
        end
        if (storeSeen) begin
            handleStore();
        end
    end

    initial begin
        fillTable();
        buildProgram();
        limitNs    = longint'(rowName.size()) * 8 * 40 * 20; // Rows, instrs, cycles, ns
        tableBuilt = 1'b1;
    end

    initial begin
        wait (tableBuilt);
        #(limitNs);
        stopWithFailure($sformatf("Timeout after %0d ns without the done store", limitNs));
    end

endmodule

`default_nettype wire

/* dv/memoryModel.sv */
`timescale 1ns/100ps
`default_nettype none

module memoryModel #(
    parameter int seedInit = 78
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               wbCyc,
    input  logic               wbStb,
    input  logic               wbWe,
    input  rvCorePkg::dataWord wbAdr,
    input  rvCorePkg::dataWord wbDatW,
    output rvCorePkg::dataWord wbDatR,
    output logic               wbAck,
    output logic               logValid,  // One pulse per completed write
    output rvCorePkg::dataWord logAdr,
    output rvCorePkg::dataWord logDat
);

    import rvCorePkg::*;

    dataWord    mem [1024];          // Word array, loaded by the testbench
    integer     seed      = seedInit;
    logic       ackReg    = 1'b0;
    dataWord    datReg    = '0;
    logic       pending   = 1'b0;    // Request seen and wait drawn
    logic [1:0] waitLeft  = 2'd0;
    logic       logReg    = 1'b0;
    dataWord    logAdrReg = '0;
    dataWord    logDatReg = '0;
    logic [9:0] index;

    assign index = wbAdr[11:2]; // Byte address to word

    always @(posedge clk) begin
        logReg <= 1'b0;
        if (reset) begin
            ackReg  <= 1'b0;
            pending <= 1'b0;
        end else if (ackReg) begin
            ackReg  <= 1'b0; // Single-cycle ack
            pending <= 1'b0;
        end else if (wbCyc && wbStb) begin
            if (!pending) begin
                pending  <= 1'b1;
                waitLeft <= 2'($random(seed)); // 0 to 3 wait cycles
            end else if (waitLeft == 2'd0) begin
                ackReg <= 1'b1;
                if (wbWe) begin
                    mem[index] <= wbDatW;
                    logReg     <= 1'b1;
                    logAdrReg  <= wbAdr;
                    logDatReg  <= wbDatW;
                end else begin
                    datReg <= mem[index]; // Valid with ack
                end
            end else begin
                waitLeft <= waitLeft - 2'd1;
            end
        end
    end

    assign wbAck    = ackReg;
    assign wbDatR   = datReg;
    assign logValid = logReg;
    assign logAdr   = logAdrReg;
    assign logDat   = logDatReg;

endmodule

`default_nettype wire

/* source/rvCore.sv */
`timescale 1ns/100ps
`default_nettype none

module rvCore #(
    parameter rvCorePkg::dataWord resetVector = '0
) (
    input  logic               clk,
    input  logic               reset,
    output logic               wbCyc,
    output logic               wbStb,
    output logic               wbWe,
    output rvCorePkg::dataWord wbAdr,
    output rvCorePkg::dataWord wbDatW,
    input  rvCorePkg::dataWord wbDatR,
    input  logic               wbAck
);

    import rvCorePkg::*;

    // Sequencer and fetch handshake
    logic    instrValid;
    dataWord instr;
    dataWord instrPc;
    logic    consume;
    logic    redirect;
    dataWord redirectTarget;

    // Sequencer and load/store requests
    logic    memRequest;
    logic    memWrite;
    logic    memDone;
    dataWord memAddress;
    dataWord memWriteData;
    dataWord memReadData;

    // Two masters into the arbiter
    logic    fetchCyc, fetchStb, fetchAck;
    dataWord fetchAdr, fetchDatR;
    logic    lsuCyc, lsuStb, lsuWe, lsuAck;
    dataWord lsuAdr, lsuDatW, lsuDatR;

    fetchUnit #(.resetVector(resetVector)) i_fetchUnit (.*);

    loadStoreUnit i_loadStoreUnit (.*);

    busArbiter i_busArbiter (.*); // Drives the shared wb port

    coreSequencer i_coreSequencer (.*);

endmodule

`default_nettype wire

/* source/coreSequencer.sv */
`timescale 1ns/100ps
`default_nettype none

module coreSequencer (
    input  logic               clk,
    input  logic               reset,
    input  logic               instrValid,
    input  rvCorePkg::dataWord instr,
    input  rvCorePkg::dataWord instrPc,
    output logic               consume,
    output logic               redirect,
    output rvCorePkg::dataWord redirectTarget,
    output logic               memRequest,
    output logic               memWrite,
    output rvCorePkg::dataWord memAddress,
    output rvCorePkg::dataWord memWriteData,
    input  logic               memDone,
    input  rvCorePkg::dataWord memReadData
);

    import rvCorePkg::*;

    seqState   state;
    dataWord   instrReg;     // Instruction in execution
    dataWord   pcReg;
    dataWord   loadData;     // Captured in the ack cycle
    opcode     opField;
    aluOpClass opClass;
    aluControl control;
    dataWord   immediate;
    dataWord   regA;
    dataWord   regB;
    dataWord   aluB;
    dataWord   aluResult;
    logic      aluZero;
    logic      useImmediate;
    logic      writesReg;
    logic      isLoad;       // Write-back source select
    logic      isMemory;
    logic      branchTaken;
    logic      regWrite;
    dataWord   regWriteData;

    assign opField = opcode'(instrReg[6:0]);

    always_comb begin
        opClass      = classAddress; // Unknown opcodes run as no-ops
        useImmediate = 1'b0;
        writesReg    = 1'b0;
        isLoad       = 1'b0;
        isMemory     = 1'b0;
        immediate    = {{20{instrReg[31]}}, instrReg[31:20]}; // I form
        case (opField)
            opLoad: begin
                useImmediate = 1'b1;
                writesReg    = 1'b1;
                isLoad       = 1'b1;
                isMemory     = 1'b1;
            end
            opStore: begin
                useImmediate = 1'b1;
                isMemory     = 1'b1;
                immediate    = {{20{instrReg[31]}}, instrReg[31:25], instrReg[11:7]};
            end
            opBranch: begin
                opClass   = classBranch;
                immediate = {{20{instrReg[31]}}, instrReg[7], instrReg[30:25],
                             instrReg[11:8], 1'b0};
            end
            opRegister: begin
                opClass   = classRegister;
                writesReg = 1'b1;
            end
            opImmediate: begin
                opClass      = classImmediate;
                useImmediate = 1'b1;
                writesReg    = 1'b1;
            end
            default: ;
        endcase
    end

    assign aluB = useImmediate ? immediate : regB;

    registerFile i_registerFile (
        .clk         (clk),
        .reset       (reset),
        .readAddrA   (instrReg[19:15]),
        .readAddrB   (instrReg[24:20]),
        .readDataA   (regA),
        .readDataB   (regB),
        .writeEnable (regWrite),
        .writeAddr   (instrReg[11:7]),
        .writeData   (regWriteData)
    );

    aluDecoder i_aluDecoder (
        .opClass (opClass),
        .funct3  (instrReg[14:12]),
        .funct75 (instrReg[30]),
        .control (control)
    );

    alu i_alu (
        .control (control),
        .a       (regA),
        .b       (aluB),
        .result  (aluResult),
        .zero    (aluZero)
    );

    // BEQ and BNE only, other funct3 never taken
    assign branchTaken = (opField == opBranch)
                       && (((instrReg[14:12] == 3'b000) && aluZero)
                       ||  ((instrReg[14:12] == 3'b001) && !aluZero));

    assign consume        = (state == stDecode) && instrValid;
    assign redirect       = (state == stExecute) && branchTaken;
    assign redirectTarget = pcReg + immediate; // B immediate
    assign memRequest     = (state == stExecute) && isMemory; // Single pulse
    assign memWrite       = (opField == opStore);
    assign memAddress     = aluResult;
    assign memWriteData   = regB;

    // Operands unchanged until write-back so the ALU result still holds
    assign regWrite     = (state == stWriteback) && writesReg;
    assign regWriteData = isLoad ? loadData : aluResult;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= stDecode;
        end else begin
            unique case (state)
                stDecode:    if (instrValid) state <= stExecute;
                stExecute:   state <= isMemory ? stMemory : stWriteback;
                stMemory:    if (memDone) state <= stWriteback; // Variable wait
                stWriteback: state <= stDecode;
                default:     state <= stDecode;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (consume) begin
            instrReg <= instr;
            pcReg    <= instrPc;
        end
        if (memDone) begin
            loadData <= memReadData;
        end
    end

    // Load/store completion only lands while waiting for it
    assert property (@(posedge clk) disable iff (reset) memDone |-> state == stMemory);

endmodule

`default_nettype wire

/* source/busArbiter.sv */
`timescale 1ns/100ps
`default_nettype none

module busArbiter (
    input  logic               clk,
    input  logic               reset,
    input  logic               fetchCyc,
    input  logic               fetchStb,
    input  rvCorePkg::dataWord fetchAdr,
    output logic               fetchAck,
    output rvCorePkg::dataWord fetchDatR,
    input  logic               lsuCyc,
    input  logic               lsuStb,
    input  logic               lsuWe,
    input  rvCorePkg::dataWord lsuAdr,
    input  rvCorePkg::dataWord lsuDatW,
    output logic               lsuAck,
    output rvCorePkg::dataWord lsuDatR,
    output logic               wbCyc,
    output logic               wbStb,
    output logic               wbWe,
    output rvCorePkg::dataWord wbAdr,
    output rvCorePkg::dataWord wbDatW,
    input  rvCorePkg::dataWord wbDatR,
    input  logic               wbAck
);

    logic owner;    // Set while the load/store unit owns the bus
    logic locked;   // Transfer still open
    logic grantLsu;

    // Keep the owner mid-transfer, else load/store first
    assign grantLsu = locked ? owner : lsuCyc;

    always_ff @(posedge clk) begin
        if (reset) begin
            owner  <= 1'b0;
            locked <= 1'b0;
        end else begin
            owner  <= grantLsu;
            locked <= wbCyc && !wbAck; // Released by the ack
        end
    end

    assign wbCyc  = grantLsu ? lsuCyc  : fetchCyc;
    assign wbStb  = grantLsu ? lsuStb  : fetchStb;
    assign wbWe   = grantLsu && lsuWe; // Fetch only reads
    assign wbAdr  = grantLsu ? lsuAdr  : fetchAdr;
    assign wbDatW = grantLsu ? lsuDatW : '0;

    // Waiting master never sees an ack
    assign fetchAck  = wbAck && !grantLsu;
    assign lsuAck    = wbAck && grantLsu;
    assign fetchDatR = wbDatR;
    assign lsuDatR   = wbDatR;

    assert property (@(posedge clk) disable iff (reset) !(fetchAck && lsuAck));

    // No switch while a transfer is open
    assert property (@(posedge clk) disable iff (reset)
        wbCyc && !wbAck |=> grantLsu == $past(grantLsu));

endmodule

`default_nettype wire

/* source/loadStoreUnit.sv */
`timescale 1ns/100ps
`default_nettype none

module loadStoreUnit (
    input  logic               clk,
    input  logic               reset,
    input  logic               memRequest,
    input  logic               memWrite,
    input  rvCorePkg::dataWord memAddress,
    input  rvCorePkg::dataWord memWriteData,
    output logic               memDone,
    output rvCorePkg::dataWord memReadData,
    output logic               lsuCyc,
    output logic               lsuStb,
    output logic               lsuWe,
    output rvCorePkg::dataWord lsuAdr,
    output rvCorePkg::dataWord lsuDatW,
    input  logic               lsuAck,
    input  rvCorePkg::dataWord lsuDatR
);

    import rvCorePkg::*;

    logic    busy;
    logic    writeReg; // Latched direction
    dataWord adrReg;
    dataWord datReg;
    logic    accept;

    assign accept = memRequest && !busy; // One transfer at a time

    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
        end else if (accept) begin
            busy <= 1'b1;
        end else if (busy && lsuAck) begin
            busy <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            writeReg <= memWrite;
            adrReg   <= memAddress;
            datReg   <= memWriteData;
        end
    end

    assign lsuCyc  = busy;
    assign lsuStb  = busy;
    assign lsuWe   = busy && writeReg;
    assign lsuAdr  = adrReg;
    assign lsuDatW = datReg;

    // Done in the ack cycle, read data valid with it
    assign memDone     = busy && lsuAck;
    assign memReadData = lsuDatR;

    // Request held steady while the slave stalls
    assert property (@(posedge clk) disable iff (reset)
        lsuStb && !lsuAck |=> $stable(lsuAdr) && $stable(lsuDatW) && $stable(lsuWe));

endmodule

`default_nettype wire

/* source/fetchUnit.sv */
`timescale 1ns/100ps
`default_nettype none

module fetchUnit #(
    parameter rvCorePkg::dataWord resetVector = '0
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               consume,
    input  logic               redirect,
    input  rvCorePkg::dataWord redirectTarget,
    output logic               instrValid,
    output rvCorePkg::dataWord instr,
    output rvCorePkg::dataWord instrPc,
    output logic               fetchCyc,
    output logic               fetchStb,
    output rvCorePkg::dataWord fetchAdr,
    input  logic               fetchAck,
    input  rvCorePkg::dataWord fetchDatR
);

    import rvCorePkg::*;

    dataWord nextPc;   // Address of the next request
    dataWord reqAdr;   // Held on the bus until ack
    dataWord bufInstr;
    dataWord bufPc;
    logic    busy;     // Transfer in flight
    logic    bufValid;
    logic    discard;  // In-flight data overtaken by a redirect
    logic    start;
    logic    ackSeen;

    // Idle bus and a free or freeing buffer
    assign start   = !busy && !redirect && (!bufValid || consume);
    assign ackSeen = busy && fetchAck;

    always_ff @(posedge clk) begin
        if (reset) begin
            nextPc   <= resetVector;
            busy     <= 1'b0;
            bufValid <= 1'b0;
            discard  <= 1'b0;
        end else begin
            if (redirect) begin
                nextPc <= redirectTarget;
            end else if (start) begin
                nextPc <= nextPc + 32'd4;
            end

            if (start) begin
                busy <= 1'b1;
            end else if (ackSeen) begin
                busy <= 1'b0; // cyc drops the cycle after ack
            end

            // Flush on redirect, refill on a live ack
            if (redirect || consume) begin
                bufValid <= 1'b0;
            end
            if (ackSeen && !discard && !redirect) begin
                bufValid <= 1'b1;
            end

            if (ackSeen) begin
                discard <= 1'b0;
            end else if (busy && redirect) begin
                discard <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            reqAdr <= nextPc;
        end
        if (ackSeen) begin
            bufInstr <= fetchDatR;
            bufPc    <= reqAdr; // Pc travels with the word
        end
    end

    assign fetchCyc   = busy;
    assign fetchStb   = busy;
    assign fetchAdr   = reqAdr;
    assign instrValid = bufValid;
    assign instr      = bufInstr;
    assign instrPc    = bufPc;

    // Request stays on the bus with cyc until the ack
    assert property (@(posedge clk) disable iff (reset)
        fetchStb && !fetchAck |=> fetchStb && fetchCyc && $stable(fetchAdr));

endmodule

`default_nettype wire

/* source/registerFile.sv */
`timescale 1ns/100ps
`default_nettype none

module registerFile (
    input  logic               clk,
    input  logic               reset,
    input  logic [4:0]         readAddrA,
    input  logic [4:0]         readAddrB,
    output rvCorePkg::dataWord readDataA,
    output rvCorePkg::dataWord readDataB,
    input  logic               writeEnable,
    input  logic [4:0]         writeAddr,
    input  rvCorePkg::dataWord writeData
);

    import rvCorePkg::*;

    dataWord regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable && (writeAddr != 5'd0)) begin // x0 not writable
            regs[writeAddr] <= writeData;
        end
    end

    // Asynchronous read ports
    assign readDataA = regs[readAddrA];
    assign readDataB = regs[readAddrB];

    // x0 reads zero on both ports whatever was written
    assert property (@(posedge clk) disable iff (reset)
        ((readAddrA == 5'd0) -> (readDataA == '0)) && ((readAddrB == 5'd0) -> (readDataB == '0)));

endmodule

`default_nettype wire

/* source/alu.sv */
`timescale 1ns/100ps
`default_nettype none

module alu (
    input  rvCorePkg::aluControl control,
    input  rvCorePkg::dataWord   a,
    input  rvCorePkg::dataWord   b,
    output rvCorePkg::dataWord   result,
    output logic                 zero
);

    import rvCorePkg::*;

    logic [4:0] shamt;        // Shift amount
    logic       lessSigned;
    logic       lessUnsigned;

    assign shamt        = b[4:0]; // Upper bits of b ignored
    assign lessSigned   = $signed(a) < $signed(b);
    assign lessUnsigned = a < b;

    always_comb begin
        unique case (control)
            aluAdd:  result = a + b;
            aluSub:  result = a - b;
            aluAnd:  result = a & b;
            aluOr:   result = a | b;
            aluXor:  result = a ^ b;
            aluSll:  result = a << shamt;
            aluSrl:  result = a >> shamt;
            aluSra:  result = $signed(a) >>> shamt; // Keeps sign bit
            aluSlt:  result = {31'b0, lessSigned};
            aluSltu: result = {31'b0, lessUnsigned};
            default: result = '0; // Unused codes
        endcase
    end

    // Branch equality test after SUB
    assign zero = (result == '0);

endmodule

`default_nettype wire

/* source/aluDecoder.sv */
`timescale 1ns/100ps
`default_nettype none

module aluDecoder (
    input  rvCorePkg::aluOpClass opClass,
    input  logic [2:0]           funct3,
    input  logic                 funct75,  // Instruction bit 30
    output rvCorePkg::aluControl control
);

    import rvCorePkg::*;

    logic subSelect; // Only register form may subtract

    assign subSelect = funct75 && (opClass == classRegister);

    always_comb begin
        unique case (opClass)
            classAddress: control = aluAdd; // Base plus offset
            classBranch:  control = aluSub; // Equality from zero flag

            // Register and immediate forms share one table
            classRegister, classImmediate: begin
                unique case (funct3)
                    3'b000: control = subSelect ? aluSub : aluAdd; // ADDI ignores bit 30
                    3'b001: control = aluSll;
                    3'b010: control = aluSlt;
                    3'b011: control = aluSltu;
                    3'b100: control = aluXor;
                    3'b101: control = funct75 ? aluSra : aluSrl; // Both forms follow bit 30
                    3'b110: control = aluOr;
                    3'b111: control = aluAnd;
                endcase
            end
        endcase
    end

endmodule

`default_nettype wire

/* source/rvCorePkg.sv */
`default_nettype none

package rvCorePkg;

    // Instruction, address or data value
    typedef logic [31:0] dataWord;

    // ALU function select
    typedef enum logic [3:0] {
        aluAdd  = 4'd0,
        aluSub  = 4'd1,
        aluAnd  = 4'd2,
        aluOr   = 4'd3,
        aluXor  = 4'd4,
        aluSll  = 4'd5,
        aluSrl  = 4'd6,
        aluSra  = 4'd7,
        aluSlt  = 4'd8, // Signed compare
        aluSltu = 4'd9  // Unsigned compare
    } aluControl;

    typedef enum logic [1:0] {
        classAddress   = 2'd0, // Loads and stores
        classBranch    = 2'd1, // Compare by subtraction
        classRegister  = 2'd2,
        classImmediate = 2'd3
    } aluOpClass;

    // Standard RV32I major opcodes
    typedef enum logic [6:0] {
        opLoad      = 7'b0000011,
        opImmediate = 7'b0010011,
        opStore     = 7'b0100011,
        opRegister  = 7'b0110011,
        opBranch    = 7'b1100011
    } opcode;

    typedef enum logic [2:0] {
        stDecode    = 3'd0,
        stExecute   = 3'd1,
        stMemory    = 3'd2, // Loads and stores only
        stWriteback = 3'd3
    } seqState;

endpackage

`default_nettype wire
